//--- build.f
logic/route_pkg.sv
logic/stream_fifo.sv
logic/route_sequencer.sv
logic/route_last_tracker.sv
logic/route_top.sv
verification/route_tb.sv

//--- logic/route_last_tracker.sv
`timescale 1ns/1ps

module route_last_tracker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  route_pkg::route_cfg_t cfg,
    input  logic                  accept,
    output logic                  last,
    output logic                  complete
);

    logic [1:0] half_cnt;
    logic [3:0] pixel;
    logic [3:0] row;
    logic [2:0] half_groups;
    logic       last_half;
    logic       last_pixel;
    logic       last_row;

    assign half_groups = cfg.channel_groups[3:1]; // Kept beats per pixel.

    assign last_half  = ({1'b0, half_cnt} == half_groups - 3'd1);
    assign last_pixel = ({1'b0, pixel} == cfg.row_len - 5'd1);
    assign last_row   = ({1'b0, row} == cfg.row_len - 5'd1);

    assign last = last_half && last_pixel && last_row;

    // Counters advance only on beats the consumer has taken.
    always_ff @(posedge clk) begin
        if (rst || start) begin
            half_cnt <= '0;
            pixel    <= '0;
            row      <= '0;
        end else if (accept) begin
            if (last_half) begin
                half_cnt <= '0;
                if (last_pixel) begin
                    pixel <= '0;
                    row   <= last_row ? '0 : row + 1'b1;
                end else begin
                    pixel <= pixel + 1'b1;
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            complete <= 1'b0;
        end else begin
            complete <= accept && last; // One cycle after the final beat.
        end
    end

endmodule

//--- logic/route_pkg.sv
package route_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int beat_width         = 64;
    localparam int max_row_len        = 16;
    localparam int max_channel_groups = 8;  // Must stay even.

    localparam int in_depth    = max_row_len * max_channel_groups; // One full row.
    localparam int out_depth   = 64;                               // Upper half of a row.
    localparam int count_width = 8;

    //////////////////////////////
    // Structs
    //////////////////////////////

    // Row count equals row length because the map is square.
    typedef struct packed {
        logic [4:0] row_len;
        logic [3:0] channel_groups;
    } route_cfg_t;

    typedef struct packed {
        logic [beat_width-1:0] data;
        logic                  last;
    } route_beat_t;

endpackage

//--- logic/route_sequencer.sv
`timescale 1ns/1ps

module route_sequencer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    input  route_pkg::route_cfg_t             cfg,
    input  logic [route_pkg::count_width-1:0] in_count,
    input  logic                              out_empty,
    output logic                              rd_en,
    output logic                              keep_wr
);

    typedef enum logic [1:0] {
        idle,
        wait_row,
        drain,
        next_row
    } state_t;

    state_t     state;
    logic [2:0] group;
    logic [3:0] pixel;
    logic [3:0] row;
    logic [8:0] row_beats;
    logic       last_group;
    logic       last_pixel;
    logic       last_row;
    logic       row_ready;

    //////////////////////////////
    // Read-side conditions
    //////////////////////////////

    assign row_beats  = cfg.row_len * cfg.channel_groups;
    assign last_group = ({1'b0, group} == cfg.channel_groups - 4'd1);
    assign last_pixel = ({1'b0, pixel} == cfg.row_len - 5'd1);
    assign last_row   = ({1'b0, row} == cfg.row_len - 5'd1);

    // A whole row must be buffered, and the previous half row must be gone.
    assign row_ready = ({1'b0, in_count} >= row_beats) && out_empty;

    assign rd_en = (state == drain); // One beat per cycle for the whole row.

    //////////////////////////////
    // Frame and row FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            group   <= '0;
            pixel   <= '0;
            row     <= '0;
            keep_wr <= 1'b0;
        end else begin
            // The read beat shows up a cycle later, so the keep flag trails rd_en by one.
            keep_wr <= (state == drain) &&
                       ({1'b0, group} >= {1'b0, cfg.channel_groups[3:1]});

            case (state)
                idle: begin
                    if (start) begin
                        state <= wait_row;
                        group <= '0;
                        pixel <= '0;
                        row   <= '0;
                    end
                end

                wait_row: begin
                    if (row_ready) begin
                        state <= drain;
                    end
                end

                drain: begin
                    if (last_group) begin
                        group <= '0;
                        if (last_pixel) begin
                            pixel <= '0;
                            state <= next_row;
                        end else begin
                            pixel <= pixel + 1'b1;
                        end
                    end else begin
                        group <= group + 1'b1;
                    end
                end

                next_row: begin
                    if (last_row) begin
                        state <= idle;  // Frame done.
                    end else begin
                        row   <= row + 1'b1;
                        state <= wait_row;
                    end
                end

                default: state <= idle;
            endcase
        end
    end

endmodule

//--- logic/route_top.sv
`timescale 1ns/1ps

module route_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  route_pkg::route_cfg_t            cfg,
    input  logic [route_pkg::beat_width-1:0] s_data,
    input  logic                             s_valid,
    output logic                             s_ready,
    output route_pkg::route_beat_t           m_beat,
    output logic                             m_valid,
    input  logic                             m_ready,
    output logic                             complete
);

    route_pkg::route_cfg_t                cfg_q;
    logic [route_pkg::beat_width-1:0]     in_dout;
    logic [route_pkg::count_width-1:0]    in_count;
    logic                                 in_full;
    logic [route_pkg::beat_width-1:0]     out_dout;
    logic                                 out_empty;
    logic                                 out_rd;
    logic                                 rd_en;
    logic                                 keep_wr;
    logic                                 route_last;

    assign s_ready = !in_full;

    // The output FIFO reads with one cycle of latency, so its head is
    // staged in dout and m_valid marks that stage as full.
    assign out_rd = !out_empty && (!m_valid || m_ready);

    assign m_beat.data = out_dout;
    assign m_beat.last = route_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q <= '0;
        end else if (start) begin
            cfg_q <= cfg;  // Held for the whole frame.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else if (out_rd) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    stream_fifo #(.depth(route_pkg::in_depth)) in_buf (
        .clk(clk), .rst(rst),
        .wr_en(s_valid && s_ready), .din(s_data),
        .rd_en(rd_en), .dout(in_dout),
        .count(in_count), .empty(), .full(in_full)
    );

    route_sequencer seq0 (
        .clk(clk), .rst(rst), .start(start), .cfg(cfg_q),
        .in_count(in_count), .out_empty(out_empty && !m_valid),
        .rd_en(rd_en), .keep_wr(keep_wr)
    );

    stream_fifo #(.depth(route_pkg::out_depth)) out_buf (
        .clk(clk), .rst(rst),
        .wr_en(keep_wr), .din(in_dout),
        .rd_en(out_rd), .dout(out_dout),
        .count(), .empty(out_empty), .full()
    );

    route_last_tracker last0 (
        .clk(clk), .rst(rst), .start(start), .cfg(cfg_q),
        .accept(m_valid && m_ready), .last(route_last), .complete(complete)
    );

endmodule

//--- logic/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter int depth = 64
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               wr_en,
    input  logic [route_pkg::beat_width-1:0]   din,
    input  logic                               rd_en,
    output logic [route_pkg::beat_width-1:0]   dout,
    output logic [route_pkg::count_width-1:0]  count,
    output logic                               empty,
    output logic                               full
);

    logic [route_pkg::beat_width-1:0] mem [depth];
    logic [$clog2(depth)-1:0]         wr_ptr;
    logic [$clog2(depth)-1:0]         rd_ptr;
    logic                             wr_ok;
    logic                             rd_ok;

    assign empty = (count == '0);
    assign full  = (int'(count) == depth);

    // Writes into a full buffer and reads from an empty one are dropped.
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    // Read data lands one cycle after rd_en and holds until the next read.
    always_ff @(posedge clk) begin
        if (rd_ok) begin
            dout <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or a write and a read together.
            endcase
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Builds the route stage testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module route_tb -o route_sim
./obj_dir/route_sim > sim.log
cat sim.log

if grep -q "TEST PASS" sim.log; then
    exit 0
fi
exit 1

//--- verification/route_input.txt
// Columns in hex: row_len  channel_groups  data_seed
// One frame per line, read until a zero row_len.
1 2 a1
2 2 b20c
3 4 c3
4 8 d4d4
5 6 e5
8 4 f60017
10 8 1234abcd
7 2 77
10 2 5eed
2 8 2828
c 6 3c3c
10 8 ffeeddccbb
6 4 64
f 6 f0f0
9 8 99
3 2 3
b 4 b0b0b0
10 6 6060
1 8 18

//--- verification/route_tb.sv
`timescale 1ns/1ps

module route_tb;

    localparam int max_frames     = 32;
    localparam int timeout_cycles = 5000;

    logic                             clk;
    logic                             rst;
    logic                             start;
    route_pkg::route_cfg_t            cfg;
    logic [route_pkg::beat_width-1:0] s_data;
    logic                             s_valid;
    logic                             s_ready;
    route_pkg::route_beat_t           m_beat;
    logic                             m_valid;
    logic                             m_ready;
    logic                             complete;

    logic [39:0] frame_words [0:3*max_frames-1]; // Row length, groups, seed per frame.
    integer      seed;
    int          errors;
    int          checks;
    int          frames;
    int          pulses = 0;

    route_top dut0 (
        .clk(clk), .rst(rst), .start(start), .cfg(cfg),
        .s_data(s_data), .s_valid(s_valid), .s_ready(s_ready),
        .m_beat(m_beat), .m_valid(m_valid), .m_ready(m_ready),
        .complete(complete)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (!rst && complete) begin
            pulses = pulses + 1;
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // The frame seed sits above the row, pixel and group indices.
    function automatic logic [route_pkg::beat_width-1:0] beat_value(
        input logic [39:0] fseed, input int r, input int p, input int g);
        beat_value = {fseed, 8'(r), 8'(p), 8'(g)};
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("Timed out while waiting for %s.", what);
        $display("errors %0d, checks %0d, frames %0d", errors + 1, checks, frames);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic send_frame(input int n, input int groups, input logic [39:0] fseed);
        int waited;
        for (int r = 0; r < n; r++) begin
            for (int p = 0; p < n; p++) begin
                for (int g = 0; g < groups; g++) begin
                    while (($random(seed) & 3) == 0) begin
                        s_valid = 1'b0; // Idle gap.
                        @(negedge clk);
                    end
                    s_valid = 1'b1;
                    s_data  = beat_value(fseed, r, p, g);
                    waited  = 0;
                    while (!s_ready) begin
                        @(negedge clk);
                        waited++;
                        if (waited > timeout_cycles) abort_on_timeout("s_ready");
                    end
                    @(negedge clk);  // The beat moved on the rising edge.
                end
            end
        end
        s_valid = 1'b0;
    endtask

    task automatic receive_frame(input int n, input int groups, input logic [39:0] fseed);
        int                               total;
        int                               half;
        int                               got;
        int                               waited;
        logic                             accepted;
        logic [route_pkg::beat_width-1:0] expect_data;
        logic                             expect_last;
        half   = groups / 2;
        total  = n * n * half;
        got    = 0;
        waited = 0;
        while (got < total) begin
            m_ready  = (($random(seed) & 3) != 0);
            accepted = m_valid && m_ready;
            if (accepted) begin
                expect_data = beat_value(fseed, got / (n * half), (got / half) % n,
                                         half + got % half);
                expect_last = (got == total - 1);
                if (m_beat.data !== expect_data) begin
                    errors++;
                    $display("CHECK FAILED m_beat.data: got %h, expected %h",
                             m_beat.data, expect_data);
                end
                if (m_beat.last !== expect_last) begin
                    errors++;
                    $display("CHECK FAILED m_beat.last: got %h, expected %h",
                             m_beat.last, expect_last);
                end
                checks += 2;
                got++;
                waited = 0;
            end else begin
                waited++;
                if (waited > timeout_cycles) abort_on_timeout("m_valid");
            end
            @(negedge clk);
            // The pulse follows only the accepted final beat.
            if (complete !== (accepted && got == total)) begin
                errors++;
                $display("CHECK FAILED complete: got %h, expected %h",
                         complete, accepted && got == total);
            end
            checks++;
        end
        m_ready = 1'b0;
        @(negedge clk);
        // The pulse has ended and no stray beat follows the frame.
        if (complete !== 1'b0) begin
            errors++;
            $display("CHECK FAILED complete: got %h, expected %h", complete, 1'b0);
        end
        if (m_valid !== 1'b0) begin
            errors++;
            $display("CHECK FAILED m_valid: got %h, expected %h", m_valid, 1'b0);
        end
        checks += 2;
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int          f;
        int          n;
        int          groups;
        logic [39:0] fseed;
        seed    = 5;
        errors  = 0;
        checks  = 0;
        frames  = 0;
        rst     = 1'b1;
        start   = 1'b0;
        cfg     = '0;
        s_data  = '0;
        s_valid = 1'b0;
        m_ready = 1'b0;
        for (int i = 0; i < 3 * max_frames; i++) begin
            frame_words[i] = '0;
        end
        $readmemh("verification/route_input.txt", frame_words);

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (m_valid !== 1'b0) begin
            errors++;
            $display("CHECK FAILED m_valid: got %h, expected %h", m_valid, 1'b0);
        end
        if (complete !== 1'b0) begin
            errors++;
            $display("CHECK FAILED complete: got %h, expected %h", complete, 1'b0);
        end
        if (s_ready !== 1'b1) begin
            errors++;
            $display("CHECK FAILED s_ready: got %h, expected %h", s_ready, 1'b1);
        end
        checks += 3;

        f = 0;
        while (f < max_frames && frame_words[3*f] != '0) begin
            n      = int'(frame_words[3*f]);
            groups = int'(frame_words[3*f+1]);
            fseed  = frame_words[3*f+2];
            cfg.row_len        = 5'(n);
            cfg.channel_groups = 4'(groups);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            fork
                send_frame(n, groups, fseed);
                receive_frame(n, groups, fseed);
            join
            frames++;
            f++;
        end

        if (frames == 0) begin
            errors++;
            $display("No frames were read from the data file.");
        end
        if (pulses != frames) begin
            errors++;
            $display("Saw %0d completion pulses for %0d frames.", pulses, frames);
        end
        $display("errors %0d, checks %0d, frames %0d", errors, checks, frames);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
